// File: common/isa_pkg.sv
`default_nettype none

package isa_pkg;

   typedef logic [15:0] word_t;        // Register and instruction word
   typedef logic [3:0]  reg_num_t;     // Register number
   typedef logic [3:0]  flags_t;       // Condition flags from the ALU

   localparam reg_num_t reg_pc   = 4'd15;
   localparam reg_num_t reg_flag = 4'd14;

   // Bit positions in the flag register
   localparam int flag_carry    = 0;
   localparam int flag_zero     = 1;
   localparam int flag_sign     = 2;
   localparam int flag_overflow = 3;
   localparam int flag_halt     = 15;

   typedef enum logic [3:0] {
      alu_add,
      alu_sub,
      alu_and,
      alu_or,
      alu_xor,
      alu_cp,                          // Subtract, flags only
      alu_sra,
      alu_srl,
      alu_sl,
      alu_rlc,
      alu_pass                         // Operand a straight through
   } alu_op_e;

   typedef enum logic [3:0] {
      op_nop,                          // Also every dropped encoding
      op_halt,
      op_alu_reg,
      op_alu_imm,                      // ADD/SUB nibble and the shift group
      op_ld_byte_lo,
      op_ld_byte_hi,
      op_ld_word_imm,                  // LD R,nnnn
      op_move,
      op_flag_op,
      op_jump,
      op_load,
      op_store
   } op_class_e;

   typedef struct packed {
      op_class_e op_class;
      alu_op_e   alu_op;
      reg_num_t  dst;
      reg_num_t  src_a;
      reg_num_t  src_b;
      logic [3:0] imm;                 // Immediate, shift amount or flag bit
      logic [7:0] byte_val;
      logic      relative;             // JR form, target is pc plus register
      logic      conditional;
      logic      cond_true;            // Jump when flag set, else when clear
      logic [1:0] cond_bit;
      logic [1:0] flag_func;           // 0 invert, 1 set, 2 clear, 3 test
      logic      writes_flags;
   } dec_t;

endpackage

`default_nettype wire

// File: common/bus_pkg.sv
`default_nettype none

package bus_pkg;

   typedef logic [15:0] bus_addr_t;    // Byte address, always even
   typedef logic [15:0] bus_data_t;    // One memory word

   typedef enum logic [1:0] {
      cmd_none  = 2'b00,               // Idle, memory ignores the bus
      cmd_read  = 2'b01,
      cmd_write = 2'b10
   } bus_cmd_e;

   // Held steady by the core until memory drops its wait level
   typedef struct packed {
      bus_cmd_e  cmd;
      bus_addr_t addr;
      bus_data_t wr_data;
   } bus_req_t;

endpackage

`default_nettype wire

// File: alu/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu (
   input  wire isa_pkg::alu_op_e op,
   input  wire isa_pkg::word_t   a,
   input  wire isa_pkg::word_t   b,
   output isa_pkg::word_t        result,
   output isa_pkg::flags_t       flags
);

   import isa_pkg::*;

   logic [16:0] sum;                   // Bit 16 is the carry out
   logic [16:0] diff;                  // Bit 16 is the borrow
   logic [16:0] ext;
   logic [31:0] rot;
   word_t       sra_val;
   logic        ovf;

   always_comb begin
      sum     = {1'b0, a} + {1'b0, b};
      diff    = {1'b0, a} - {1'b0, b};
      rot     = {a, a} << b[3:0];      // Upper half is a rotated left
      sra_val = $signed(a) >>> b[3:0];
      ovf     = 1'b0;
      case (op)
         alu_add: begin
            ext = sum;
            ovf = (a[15] == b[15]) && (sum[15] != a[15]);  // Same signs in, sign flips
         end
         alu_sub, alu_cp: begin
            ext = diff;
            ovf = (a[15] != b[15]) && (diff[15] != a[15]);
         end
         alu_and: ext = {1'b0, a & b};
         alu_or:  ext = {1'b0, a | b};
         alu_xor: ext = {1'b0, a ^ b};
         alu_sra: ext = {1'b0, sra_val};
         alu_srl: ext = {1'b0, a >> b[3:0]};
         alu_sl:  ext = {1'b0, a << b[3:0]};
         alu_rlc: ext = {1'b0, rot[31:16]};
         default: ext = {1'b0, a};     // Pass for moves
      endcase
      // Logic ops report even parity in the overflow bit
      if (op inside {alu_and, alu_or, alu_xor}) begin
         ovf = ~^ext[15:0];
      end
      result               = ext[15:0];
      flags[flag_carry]    = ext[16];  // Cleared for logic ops by the zero pad
      flags[flag_zero]     = (ext[15:0] == 16'h0000);
      flags[flag_sign]     = ext[15];
      flags[flag_overflow] = ovf;
   end

endmodule

`default_nettype wire

// File: src/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file (
   input  wire logic              clk,
   input  wire logic              reset,
   input  wire isa_pkg::reg_num_t raddr_a,
   input  wire isa_pkg::reg_num_t raddr_b,
   output isa_pkg::word_t         rdata_a,
   output isa_pkg::word_t         rdata_b,
   input  wire logic              we,
   input  wire isa_pkg::reg_num_t waddr,
   input  wire isa_pkg::word_t    wdata,
   input  wire logic              flags_we,
   input  wire isa_pkg::word_t    flags_wdata,
   input  wire logic              pc_we,
   input  wire isa_pkg::word_t    pc_wdata,
   output isa_pkg::word_t         pc,
   output isa_pkg::word_t         flags
);

   import isa_pkg::*;

   word_t regs [16];                   // r15 pc, r14 flags

   // Later assignments win, so the general port overrides pc and flags
   always_ff @(posedge clk) begin
      if (reset) begin
         regs[reg_pc]   <= '0;
         regs[reg_flag] <= '0;
      end else begin
         if (pc_we) regs[reg_pc] <= pc_wdata;
         if (flags_we) regs[reg_flag] <= flags_wdata;
         if (we) regs[waddr] <= wdata;
      end
   end

   assign rdata_a = regs[raddr_a];     // Async read, sees pre-edge value
   assign rdata_b = regs[raddr_b];
   assign pc      = regs[reg_pc];
   assign flags   = regs[reg_flag];

   // Jump targets and loads into r15 come from program data
   pc_even : assert property (@(posedge clk) disable iff (reset) pc[0] == 1'b0)
      else $error("pc went odd: %h", pc);

endmodule

`default_nettype wire

// File: src/decoder.sv
`timescale 1ns/10ps
`default_nettype none

module decoder (
   input  wire isa_pkg::word_t ins,
   output isa_pkg::dec_t       dec
);

   import isa_pkg::*;

   always_comb begin
      dec = '0;                        // Class nop, no flag write
      casez (ins)
         16'b0000_0000_0000_0001: dec.op_class = op_halt;
         16'b0000_0001_0111_????: begin  // LD R,nnnn
            dec.op_class = op_ld_word_imm;
            dec.dst      = ins[3:0];
         end
         16'b0000_0001_10??_????: begin  // INVF, SETF, CLRF, TESTF
            dec.op_class  = op_flag_op;
            dec.flag_func = ins[5:4];
            dec.imm       = ins[3:0];    // Flag bit number
         end
         16'b0000_0001_111?_????: begin  // JP R and JR R
            dec.op_class = op_jump;
            dec.relative = ins[4];
            dec.src_a    = ins[3:0];
         end
         16'b0000_0011_????_????: begin  // Conditional JP/JR on flags 0 to 3
            dec.op_class    = op_jump;
            dec.relative    = ins[7];
            dec.conditional = 1'b1;
            dec.cond_true   = ins[6];
            dec.cond_bit    = ins[5:4];
            dec.src_a       = ins[3:0];
         end
         16'b0000_01??_????_????: begin  // Shift group, no flags
            dec.op_class = op_alu_imm;
            dec.dst      = ins[7:4];
            dec.src_a    = ins[7:4];
            dec.imm      = ins[3:0];
            case (ins[9:8])
               2'd0:    dec.alu_op = alu_sra;
               2'd1:    dec.alu_op = alu_srl;
               2'd2:    dec.alu_op = alu_sl;
               default: dec.alu_op = alu_rlc;
            endcase
         end
         16'b0000_100?_????_????: begin  // ADD R,n and SUB R,n
            dec.op_class     = op_alu_imm;
            dec.alu_op       = ins[8] ? alu_sub : alu_add;
            dec.dst          = ins[7:4];
            dec.src_a        = ins[7:4];
            dec.imm          = ins[3:0];
            dec.writes_flags = 1'b1;
         end
         16'b0001_????_????_????,
         16'b0010_????_????_????: begin  // Byte immediate into low or high half
            dec.op_class = ins[13] ? op_ld_byte_hi : op_ld_byte_lo;
            dec.dst      = ins[11:8];
            dec.src_a    = ins[11:8];    // Other half kept from old value
            dec.byte_val = ins[7:0];
         end
         16'b0011_0100_????_????,
         16'b0011_0110_????_????: begin  // Word store/load, data A, address B
            dec.op_class = ins[9] ? op_load : op_store;
            dec.dst      = ins[7:4];
            dec.src_a    = ins[7:4];
            dec.src_b    = ins[3:0];
         end
         16'b0011_11??_????_????: begin  // Moves, register field bit 4 ignored
            dec.op_class = op_move;
            dec.alu_op   = alu_pass;
            dec.dst      = ins[9] ? ins[7:4] : ins[3:0];
            dec.src_a    = ins[9] ? ins[3:0] : ins[7:4];
         end
         16'b1???_????_????_????: begin  // Three-register ALU
            dec.op_class     = op_alu_reg;
            dec.dst          = ins[11:8];
            dec.src_a        = ins[7:4];
            dec.src_b        = ins[3:0];
            dec.writes_flags = 1'b1;
            case (ins[14:12])
               3'd0:    dec.alu_op = alu_add;
               3'd1:    dec.alu_op = alu_sub;
               3'd4:    dec.alu_op = alu_and;
               3'd5:    dec.alu_op = alu_or;
               3'd6:    dec.alu_op = alu_xor;
               3'd7:    dec.alu_op = alu_cp;
               default: dec = '0;        // MUL and DIV
            endcase
         end
         default: dec = '0;
      endcase
   end

endmodule

`default_nettype wire

// File: src/control_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module control_fsm #(
   parameter bus_pkg::bus_addr_t reset_addr = '0
) (
   input  wire logic               clk,
   input  wire logic               reset,
   input  wire isa_pkg::dec_t      dec,
   input  wire bus_pkg::bus_data_t rd_data,
   input  wire logic               mem_wait,
   input  wire isa_pkg::word_t     pc,
   input  wire isa_pkg::word_t     flags,
   input  wire isa_pkg::word_t     rdata_a,
   input  wire isa_pkg::word_t     rdata_b,
   input  wire isa_pkg::word_t     alu_result,
   input  wire isa_pkg::flags_t    alu_flags,
   output logic                    we,
   output isa_pkg::reg_num_t       waddr,
   output isa_pkg::word_t          wdata,
   output logic                    flags_we,
   output isa_pkg::word_t          flags_wdata,
   output logic                    pc_we,
   output isa_pkg::word_t          pc_wdata,
   output isa_pkg::alu_op_e        alu_op,
   output isa_pkg::word_t          alu_b,
   output isa_pkg::reg_num_t       raddr_a,
   output isa_pkg::reg_num_t       raddr_b,
   output bus_pkg::bus_req_t       bus_req,
   output logic                    halted
);

   import isa_pkg::*;
   import bus_pkg::*;

   typedef enum logic {
      st_fetch_exec,                   // rd_data holds the instruction
      st_data_rw                       // rd_data holds load data
   } state_e;

   state_e    state;
   reg_num_t  pend_dst;                // Load target while data access runs
   logic      advance;
   logic      cond_ok;
   word_t     pc_next;
   word_t     jump_target;
   word_t     flag_mask;
   bus_cmd_e  data_cmd;
   bus_addr_t data_addr;
   bus_addr_t fetch_addr;
   logic      halt_next;

   assign advance = (bus_req.cmd != cmd_none) && !mem_wait;  // Access completes this edge
   assign halted  = flags[flag_halt];

   always_comb begin
      raddr_a     = dec.src_a;
      raddr_b     = dec.src_b;
      alu_op      = dec.alu_op;
      alu_b       = (dec.op_class == op_alu_imm) ? word_t'(dec.imm) : rdata_b;
      cond_ok     = (flags[dec.cond_bit] == dec.cond_true);
      pc_next     = pc + 16'd2;
      jump_target = dec.relative ? pc + rdata_a : rdata_a;  // JR is relative to this instr
      flag_mask   = word_t'(1) << dec.imm;
      we          = 1'b0;
      waddr       = dec.dst;
      wdata       = alu_result;
      flags_we    = 1'b0;
      flags_wdata = {flags[15:4], alu_flags};  // Halt and upper bits kept
      pc_we       = 1'b0;
      pc_wdata    = pc_next;
      data_cmd    = cmd_none;
      data_addr   = rdata_b;
      if (state == st_data_rw) begin
         we    = advance && (bus_req.cmd == cmd_read);  // Stores write nothing back
         waddr = pend_dst;
         wdata = rd_data;
      end else if (advance) begin
         pc_we = 1'b1;
         case (dec.op_class)
            op_halt: begin
               flags_we               = 1'b1;
               flags_wdata            = flags;
               flags_wdata[flag_halt] = 1'b1;
            end
            op_alu_reg, op_alu_imm: begin
               we       = (dec.alu_op != alu_cp);  // CP only sets flags
               flags_we = dec.writes_flags;
            end
            op_ld_byte_lo: begin
               we    = 1'b1;
               wdata = {rdata_a[15:8], dec.byte_val};
            end
            op_ld_byte_hi: begin
               we    = 1'b1;
               wdata = {dec.byte_val, rdata_a[7:0]};
            end
            op_ld_word_imm: begin
               data_cmd  = cmd_read;
               data_addr = pc_next;    // Literal follows the opcode
               pc_wdata  = pc + 16'd4;
            end
            op_move: we = 1'b1;
            op_flag_op: begin
               flags_we = 1'b1;
               case (dec.flag_func)
                  2'd0:    flags_wdata = flags ^ flag_mask;
                  2'd1:    flags_wdata = flags | flag_mask;
                  2'd2:    flags_wdata = flags & ~flag_mask;
                  default: begin       // TESTF, zero set when bit is clear
                     flags_wdata            = flags;
                     flags_wdata[flag_zero] = ~flags[dec.imm];
                  end
               endcase
            end
            op_jump: begin
               if (!dec.conditional || cond_ok) pc_wdata = jump_target;
            end
            op_load:  data_cmd = cmd_read;
            op_store: data_cmd = cmd_write;
            default: ;                 // NOP and dropped opcodes
         endcase
      end
      // A general write to r15 or r14 overrides pc and flags in reg_file
      if (we && waddr == reg_pc) begin
         fetch_addr = wdata;
      end else begin
         fetch_addr = pc_we ? pc_wdata : pc;
      end
      if (we && waddr == reg_flag) begin
         halt_next = wdata[flag_halt];
      end else begin
         halt_next = flags_we ? flags_wdata[flag_halt] : flags[flag_halt];
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state   <= st_fetch_exec;
         bus_req <= '{cmd: cmd_read, addr: reset_addr, wr_data: '0};  // First fetch
      end else if (advance) begin
         if (halt_next) begin
            state       <= st_fetch_exec;
            bus_req.cmd <= cmd_none;   // Bus stays idle until reset
         end else if (data_cmd != cmd_none) begin
            state   <= st_data_rw;
            bus_req <= '{cmd: data_cmd, addr: data_addr, wr_data: rdata_a};
         end else begin
            state   <= st_fetch_exec;
            bus_req <= '{cmd: cmd_read, addr: fetch_addr, wr_data: '0};
         end
      end
   end

   always_ff @(posedge clk) begin
      if (advance && data_cmd == cmd_read) pend_dst <= dec.dst;
   end

   halt_idle : assert property (@(posedge clk) disable iff (reset)
      halted |-> bus_req.cmd == cmd_none)
      else $error("bus active while halted");

   req_stable : assert property (@(posedge clk) disable iff (reset)
      (bus_req.cmd != cmd_none && mem_wait) |=> $stable(bus_req))
      else $error("bus request changed under wait");

endmodule

`default_nettype wire

// File: src/h16_cpu.sv
`timescale 1ns/10ps
`default_nettype none

module h16_cpu #(
   parameter bus_pkg::bus_addr_t reset_addr = '0
) (
   input  wire logic               clk,
   input  wire logic               reset,
   output bus_pkg::bus_req_t       bus_req,
   input  wire bus_pkg::bus_data_t rd_data,
   input  wire logic               mem_wait,
   output logic                    halted
);

   import isa_pkg::*;

   dec_t     dec;
   alu_op_e  alu_op;
   word_t    alu_b;
   word_t    alu_result;
   flags_t   alu_flags;
   reg_num_t raddr_a;
   reg_num_t raddr_b;
   word_t    rdata_a;
   word_t    rdata_b;
   logic     we;
   reg_num_t waddr;
   word_t    wdata;
   logic     flags_we;
   word_t    flags_wdata;
   logic     pc_we;
   word_t    pc_wdata;
   word_t    pc;
   word_t    flags;

   // Read data is decoded every cycle, used only in the fetch state
   decoder i_decoder (
      .ins (rd_data),
      .dec (dec)
   );

   alu i_alu (
      .op     (alu_op),
      .a      (rdata_a),               // Port a always from the register file
      .b      (alu_b),
      .result (alu_result),
      .flags  (alu_flags)
   );

   reg_file i_reg_file (
      .clk         (clk),
      .reset       (reset),
      .raddr_a     (raddr_a),
      .raddr_b     (raddr_b),
      .rdata_a     (rdata_a),
      .rdata_b     (rdata_b),
      .we          (we),
      .waddr       (waddr),
      .wdata       (wdata),
      .flags_we    (flags_we),
      .flags_wdata (flags_wdata),
      .pc_we       (pc_we),
      .pc_wdata    (pc_wdata),
      .pc          (pc),
      .flags       (flags)
   );

   control_fsm #(
      .reset_addr (reset_addr)
   ) i_control_fsm (
      .clk         (clk),
      .reset       (reset),
      .dec         (dec),
      .rd_data     (rd_data),
      .mem_wait    (mem_wait),
      .pc          (pc),
      .flags       (flags),
      .rdata_a     (rdata_a),
      .rdata_b     (rdata_b),
      .alu_result  (alu_result),
      .alu_flags   (alu_flags),
      .we          (we),
      .waddr       (waddr),
      .wdata       (wdata),
      .flags_we    (flags_we),
      .flags_wdata (flags_wdata),
      .pc_we       (pc_we),
      .pc_wdata    (pc_wdata),
      .alu_op      (alu_op),
      .alu_b       (alu_b),
      .raddr_a     (raddr_a),
      .raddr_b     (raddr_b),
      .bus_req     (bus_req),
      .halted      (halted)
   );

endmodule

`default_nettype wire

// File: bench/tb_model.svh
logic [15:0] prog_img [1024];
logic [15:0] data_img [64];              // Preload of the data window at 0x8000
logic [15:0] model_mem [32768];
logic [1:0]  exp_cmd [$];                // Expected bus stream in access order
logic [15:0] exp_addr [$];
logic [15:0] exp_data [$];
int          prog_len;

function automatic logic [3:0] pick_reg(input int range);
   return 4'({$random(seed)} % range);
endfunction

function automatic logic [15:0] alu3_word();  // ADD SUB AND OR XOR CP
   logic [2:0] ops [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
   return {1'b1, ops[{$random(seed)} % 6], pick_reg(14), pick_reg(16), pick_reg(16)};
endfunction

task automatic emit(input logic [15:0] w);
   prog_img[prog_len] = w;
   prog_len++;
endtask

task automatic gen_program();
   logic [3:0]  r;
   logic        rel, cond, ct, dir, b8;
   logic [1:0]  cb;
   logic [15:0] ja;
   int          kind;
   prog_len = 0;
   foreach (data_img[i]) data_img[i] = 16'($random(seed));
   for (int i = 0; i < 14; i++) begin    // Every register gets a known value
      emit(16'h0170 | 16'(i));
      emit(16'($random(seed)));
   end
   for (int i = 0; i < 200; i++) begin
      kind = {$random(seed)} % 10;
      r    = pick_reg(14);               // Never r14 or r15 as target
      rel  = 1'($random(seed));
      cond = 1'($random(seed));
      ct   = 1'($random(seed));
      dir  = 1'($random(seed));
      b8   = 1'($random(seed));          // Ignored register field bit
      cb   = 2'($random(seed));
      case (kind)
         0: emit(alu3_word());
         1: emit({7'b0000_100, rel, r, 4'($random(seed))});  // ADD/SUB R,n
         2: emit({6'b0000_01, cb, r, 4'($random(seed))});    // Shift group
         3: emit({2'b00, dir, ~dir, r, 8'($random(seed))});  // Byte hi or lo
         4: emit(dir ? {7'b0011_111, b8, r, pick_reg(16)} : {7'b0011_110, b8, pick_reg(16), r});
         5: emit({10'b0000_0001_10, cb, 2'b00, 2'($random(seed))});  // Flag op on bits 0 to 3
         6: begin
            emit(16'h0170 | 16'(r));
            emit(16'($random(seed)));
         end
         7: begin                        // Target skips one filler word
            ja = 16'((prog_len + 2) * 2);
            emit(16'h0170 | 16'(r));
            emit(rel ? 16'd4 : ja + 16'd4);
            emit(cond ? {8'h03, rel, ct, cb, r} : {11'b0000_0001_111, rel, r});
            emit(alu3_word());
         end
         default: begin                  // Kind 8 loads and kind 9 stores
            emit(16'h0170 | 16'(r));
            emit(16'h8000 + 16'(2 * ({$random(seed)} % 64)));
            emit({(kind == 8) ? 8'h36 : 8'h34, pick_reg((kind == 8) ? 14 : 16), r});
         end
      endcase
   end
   emit(16'h0001);                       // HALT
endtask

function automatic logic [19:0] alu_ref(input logic [2:0] op, input logic [15:0] a, b);
   logic [16:0] t;
   logic        v;
   case (op)
      3'd0:       t = {1'b0, a} + {1'b0, b};
      3'd1, 3'd7: t = {1'b0, a} - {1'b0, b};
      3'd4:       t = {1'b0, a & b};
      3'd5:       t = {1'b0, a | b};
      default:    t = {1'b0, a ^ b};
   endcase
   if (op == 3'd0) v = (a[15] == b[15]) && (t[15] != a[15]);
   else if (op == 3'd1 || op == 3'd7) v = (a[15] != b[15]) && (t[15] != a[15]);
   else v = ~^t[15:0];                   // Even parity for logic ops
   return {v, t[15], t[15:0] == 16'h0000, t[16], t[15:0]};
endfunction

function automatic logic [15:0] shift_ref(input logic [1:0] sel, input logic [15:0] a,
                                          input logic [3:0] n);
   case (sel)
      2'd0:    return 16'($signed(a) >>> n);
      2'd1:    return a >> n;
      2'd2:    return a << n;
      default: return (n == 4'd0) ? a : (a << n) | (a >> (16 - int'(n)));
   endcase
endfunction

task automatic push(input logic [1:0] c, input logic [15:0] ad, input logic [15:0] dt);
   exp_cmd.push_back(c);
   exp_addr.push_back(ad);
   exp_data.push_back(dt);
endtask

task automatic run_model();
   logic [15:0] r [16];
   logic [15:0] pc, ins, a, b, mask;
   logic [19:0] res;
   foreach (r[i]) r[i] = '0;
   pc = '0;
   for (int steps = 0; steps < 4000; steps++) begin
      r[15] = pc;                        // Reads of r15 see this instruction
      ins   = model_mem[pc[15:1]];
      push(2'd1, pc, 16'h0);
      a     = r[ins[7:4]];
      b     = r[ins[3:0]];
      mask  = 16'h1 << ins[3:0];
      pc    = pc + 16'd2;
      if (ins == 16'h0001) begin
         r[14][15] = 1'b1;
         break;
      end else if (ins[15]) begin
         res = alu_ref(ins[14:12], a, b);
         if (ins[14:12] != 3'd7) r[ins[11:8]] = res[15:0];
         r[14][3:0] = res[19:16];
      end else if (ins[15:12] == 4'h3) begin
         if (ins[11:10] == 2'b11) r[ins[9] ? ins[7:4] : ins[3:0]] = ins[9] ? b : a;
         else if (ins[9]) begin          // Load
            push(2'd1, b, 16'h0);
            r[ins[7:4]] = model_mem[b[15:1]];
         end else begin
            push(2'd2, b, a);
            model_mem[b[15:1]] = a;
         end
      end else if (ins[15:12] != 4'h0) begin
         b = r[ins[11:8]];
         r[ins[11:8]] = ins[13] ? {ins[7:0], b[7:0]} : {b[15:8], ins[7:0]};
      end else if (ins[11:9] == 3'b100) begin
         res = alu_ref({2'b00, ins[8]}, a, 16'(ins[3:0]));
         r[ins[7:4]] = res[15:0];
         r[14][3:0]  = res[19:16];
      end else if (ins[11:10] == 2'b01) begin
         r[ins[7:4]] = shift_ref(ins[9:8], a, ins[3:0]);
      end else if (ins[11:8] == 4'h3) begin
         if (r[14][ins[5:4]] == ins[6]) pc = ins[7] ? r[15] + b : b;
      end else if (ins[11:4] == 8'h17) begin  // Literal word after opcode
         push(2'd1, pc, 16'h0);
         r[ins[3:0]] = model_mem[pc[15:1]];
         pc = pc + 16'd2;
      end else if (ins[11:6] == 6'b0001_10) begin
         case (ins[5:4])
            2'd0:    r[14] = r[14] ^ mask;
            2'd1:    r[14] = r[14] | mask;
            2'd2:    r[14] = r[14] & ~mask;
            default: r[14][1] = ~r[14][ins[3:0]];
         endcase
      end else if (ins[11:5] == 7'b0001_111) begin
         pc = ins[4] ? r[15] + b : b;
      end
   end
endtask

// File: bench/tb_h16_cpu.sv
`timescale 1ns/10ps
`default_nettype none

module tb_h16_cpu;

   import bus_pkg::*;

   logic      clk;
   logic      reset;
   bus_req_t  bus_req;
   bus_data_t rd_data;
   logic      mem_wait;
   logic      halted;
   integer    seed;
   logic [15:0] mem [32768];             // Word memory indexed by addr[15:1]
   int        exp_idx;
   int        cycles;
   int        cycle_limit;
   int        wait_left;
   logic      fresh;                     // Next request gets a new wait count
   logic      zero_wait;
   string     run_name;

   `include "tb_model.svh"

   h16_cpu #(
      .reset_addr (16'h0000)
   ) i_h16_cpu (
      .clk      (clk),
      .reset    (reset),
      .bus_req  (bus_req),
      .rd_data  (rd_data),
      .mem_wait (mem_wait),
      .halted   (halted)
   );

   assign rd_data = mem[bus_req.addr[15:1]];

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("*** TEST FAILED ***");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         fail_run($sformatf("Error: %s expected %h actual %h", name, expected, actual));
      end
   endtask

   task automatic load_memory();
      for (int i = 0; i < 32768; i++) mem[i] = 16'({i[14:0], 1'b0} ^ 16'h5a5a);
      for (int i = 0; i < prog_len; i++) mem[i] = prog_img[i];
      for (int i = 0; i < 64; i++) mem[16'h4000 + i] = data_img[i];
   endtask

   always @(posedge clk) begin
      cycles++;
      if (cycles > cycle_limit) fail_run("Timeout, the core did not halt in time");
   end

   // Check completed accesses and pick the next wait count
   always @(posedge clk) begin
      if (reset) begin
         fresh = 1'b1;
      end else if (bus_req.cmd != cmd_none) begin
         if (!mem_wait) begin
            if (exp_idx >= exp_cmd.size()) fail_run("Bus access after the end of the program");
            check_value($sformatf("%s access %0d cmd", run_name, exp_idx),
                        32'(exp_cmd[exp_idx]), 32'(bus_req.cmd));
            check_value($sformatf("%s access %0d addr", run_name, exp_idx),
                        32'(exp_addr[exp_idx]), 32'(bus_req.addr));
            if (bus_req.cmd == cmd_write) begin
               check_value($sformatf("%s access %0d data", run_name, exp_idx),
                           32'(exp_data[exp_idx]), 32'(bus_req.wr_data));
               mem[bus_req.addr[15:1]] = bus_req.wr_data;
            end
            exp_idx++;
            fresh = 1'b1;
         end else begin
            wait_left--;
         end
      end
      #1;
      if (bus_req.cmd != cmd_none && fresh) begin
         wait_left = zero_wait ? 0 : {$random(seed)} % 4;  // 0 to 3 wait cycles
         fresh     = 1'b0;
      end
      mem_wait = (bus_req.cmd != cmd_none) && (wait_left > 0);
   end

   initial begin
      reset       = 1'b1;
      mem_wait    = 1'b0;
      seed        = 62;
      exp_idx     = 0;
      cycles      = 0;
      wait_left   = 0;
      fresh       = 1'b1;
      zero_wait   = 1'b0;
      run_name    = "random wait";
      cycle_limit = 1000000;
      gen_program();
      load_memory();
      model_mem = mem;
      run_model();
      cycle_limit = 2 * (exp_cmd.size() * 4 + 8 + 20) + 100;  // Both runs at worst wait
      for (int run = 0; run < 2; run++) begin
         #1;                             // Step off the clock edge
         zero_wait = (run == 1);         // Second run repeats with no wait
         run_name  = (run == 1) ? "zero wait" : "random wait";
         load_memory();
         exp_idx = 0;
         reset   = 1'b1;
         repeat (8) @(posedge clk);
         #1 reset = 1'b0;
         check_value({run_name, " halted after reset"}, 32'd0, 32'(halted));
         while (!halted) @(posedge clk);
         check_value({run_name, " access count at halt"}, exp_cmd.size(), exp_idx);
         repeat (20) @(posedge clk);
         check_value({run_name, " halted after idle"}, 32'd1, 32'(halted));
      end
      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

`default_nettype wire

// File: list.f
+incdir+bench
common/isa_pkg.sv
common/bus_pkg.sv
alu/alu.sv
src/reg_file.sv
src/decoder.sv
src/control_fsm.sv
src/h16_cpu.sv
bench/tb_h16_cpu.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module tb_h16_cpu -Mdir build \
		-o Vtb_h16_cpu -f list.f
	./build/Vtb_h16_cpu | tee /dev/stderr | grep -qF "*** TEST PASSED ***"

clean:
	rm -rf build
